//--- dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// word and line geometry
`define DC_DATA_W         32
`define DC_WORDS_PER_LINE 4
`define DC_LINE_W         128

// set geometry, direct mapped
`define DC_SETS           16
`define DC_INDEX_W        4

// byte offset within a line
`define DC_OFFSET_W       4

// 32 - index - offset
`define DC_TAG_W          24

// one strobe per byte of a word
`define DC_STRB_W         4

`endif

//--- dcache_pkg.sv
`default_nettype none
`include "dcache_macros.svh"

package dcache_pkg;

    typedef enum logic {
        op_load,
        op_store
    } dc_op_e;

    typedef enum logic [2:0] {
        ms_idle,
        ms_wb_req,      // victim line waiting for wr_rdy
        ms_wb_wait,     // waiting for wr_done
        ms_refill_req,
        ms_refill_wait,
        ms_refill_done
    } miss_state_e;

    typedef struct packed {
        dc_op_e                   op;
        logic [`DC_TAG_W-1:0]     tag;
        logic [`DC_INDEX_W-1:0]   index;
        logic [`DC_OFFSET_W-1:0]  offset;
        logic [`DC_DATA_W-1:0]    wdata;
        logic [`DC_STRB_W-1:0]    wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic                     valid;
        logic [`DC_DATA_W-1:0]    rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic                     rd_req;
        logic                     wr_req;
        logic [`DC_DATA_W-1:0]    addr;     // line aligned byte address
        logic [`DC_LINE_W-1:0]    wr_data;
    } mem_req_t;

    typedef struct packed {
        logic                     rd_rdy;
        logic                     wr_rdy;
        logic                     ret_valid;
        logic                     wr_done;
        logic [`DC_LINE_W-1:0]    ret_data;
    } mem_resp_t;

    typedef struct packed {
        logic                     fill;     // whole line, else one word
        logic [`DC_INDEX_W-1:0]   index;
        logic [`DC_TAG_W-1:0]     tag;
        logic [`DC_OFFSET_W-3:0]  word_sel;
        logic [`DC_DATA_W-1:0]    word_data;
        logic [`DC_LINE_W-1:0]    line_data;
        logic                     dirty;
    } array_wr_t;

endpackage

`default_nettype wire

//--- dcache_arrays.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_arrays import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_en,
    input  logic [`DC_INDEX_W-1:0] rd_index,
    output logic [`DC_TAG_W-1:0]   rd_tag,
    output logic                   rd_valid,
    output logic                   rd_dirty,
    output logic [`DC_LINE_W-1:0]  rd_line,
    input  array_wr_t              wr,
    input  logic                   wr_en
);

    logic [`DC_TAG_W-1:0]  tag_mem  [`DC_SETS];
    logic [`DC_LINE_W-1:0] data_mem [`DC_SETS];
    logic [`DC_SETS-1:0]   valid_bits;
    logic [`DC_SETS-1:0]   dirty_bits;
    logic [`DC_LINE_W-1:0] new_line;
    logic                  fwd;

    // line as it looks after this cycle's write
    always_comb begin
        new_line = data_mem[wr.index];
        if (wr.fill) begin
            new_line = wr.line_data;
        end else begin
            new_line[wr.word_sel*`DC_DATA_W +: `DC_DATA_W] = wr.word_data;
        end
    end

    // read and write of the same set on one edge return the new contents
    assign fwd = wr_en && (wr.index == rd_index);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr.index] <= new_line;
            tag_mem[wr.index]  <= wr.tag;   // unchanged on a store hit
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            if (wr.fill) begin
                valid_bits[wr.index] <= 1'b1;
            end
            dirty_bits[wr.index] <= wr.dirty;   // fill clears, word write sets
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (fwd) begin
                rd_line  <= new_line;
                rd_tag   <= wr.tag;
                rd_valid <= valid_bits[rd_index] | wr.fill;
                rd_dirty <= wr.dirty;
            end else begin
                rd_line  <= data_mem[rd_index];
                rd_tag   <= tag_mem[rd_index];
                rd_valid <= valid_bits[rd_index];
                rd_dirty <= dirty_bits[rd_index];
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_lookup.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_lookup import dcache_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             req_valid,
    input  cpu_req_t                         req,
    output logic                             busy,
    output cpu_resp_t                        resp,
    output logic [`DC_INDEX_W-1:0]           rd_index,
    input  logic [`DC_TAG_W-1:0]             rd_tag,
    input  logic                             rd_valid,
    input  logic                             rd_dirty,
    input  logic [`DC_LINE_W-1:0]            rd_line,
    output logic                             miss,
    output logic                             miss_dirty,
    output logic [`DC_TAG_W-1:0]             victim_tag,
    output logic [`DC_TAG_W+`DC_INDEX_W-1:0] req_tag_index,
    input  logic                             refill_done,
    output array_wr_t                        st_wr
);

    cpu_req_t              req_q;
    logic                  vld_q;       // compare cycle
    logic                  wait_q;      // miss outstanding
    logic                  st_pend;     // store write next edge
    logic [`DC_DATA_W-1:0] st_word;
    logic [`DC_DATA_W-1:0] cur_word;
    logic [`DC_DATA_W-1:0] merged;
    logic                  hit;
    logic                  is_store;
    logic                  accept;

    assign hit      = rd_valid && (rd_tag == req_q.tag);
    assign is_store = (req_q.op == op_store);
    assign cur_word = rd_line[req_q.offset[`DC_OFFSET_W-1:2]*`DC_DATA_W +: `DC_DATA_W];

    // strobed bytes replace the stored ones
    always_comb begin
        for (int b = 0; b < `DC_STRB_W; b++) begin
            merged[b*8 +: 8] = req_q.wstrb[b] ? req_q.wdata[b*8 +: 8] : cur_word[b*8 +: 8];
        end
    end

    // a store hit holds off the next request for one cycle
    assign busy   = wait_q | (vld_q & (~hit | is_store));
    assign accept = req_valid & ~busy;

    assign resp.valid = vld_q & hit;
    assign resp.rdata = cur_word;

    assign rd_index = wait_q ? req_q.index : req.index;   // re-read after refill

    assign miss          = vld_q & ~hit;
    assign miss_dirty    = rd_valid & rd_dirty;
    assign victim_tag    = rd_tag;
    assign req_tag_index = {req_q.tag, req_q.index};

    always_comb begin
        st_wr           = '0;
        st_wr.index     = req_q.index;
        st_wr.tag       = req_q.tag;
        st_wr.word_sel  = req_q.offset[`DC_OFFSET_W-1:2];
        st_wr.word_data = st_word;
        st_wr.dirty     = st_pend;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q   <= 1'b0;
            wait_q  <= 1'b0;
            st_pend <= 1'b0;
        end else begin
            vld_q   <= accept | refill_done;
            st_pend <= vld_q & hit & is_store;
            if (miss) begin
                wait_q <= 1'b1;
            end else if (refill_done) begin
                wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (vld_q && hit) begin
            st_word <= merged;
        end
    end

    // one miss per request, none while the previous one is still in flight
    a_no_nested_miss: assert property (@(posedge clk) disable iff (reset)
        miss |-> !wait_q);

endmodule

`default_nettype wire

//--- dcache_miss_ctrl.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_miss_ctrl import dcache_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             miss,
    input  logic                             miss_dirty,
    input  logic [`DC_TAG_W-1:0]             victim_tag,
    input  logic [`DC_TAG_W+`DC_INDEX_W-1:0] req_tag_index,
    input  logic [`DC_LINE_W-1:0]            victim_line,
    output mem_req_t                         mem_req,
    input  mem_resp_t                        mem_resp,
    output array_wr_t                        fill_wr,
    output logic                             active,
    output logic                             refill_done
);

    miss_state_e                      state;
    miss_state_e                      state_nxt;
    logic [`DC_TAG_W-1:0]             victim_tag_q;
    logic [`DC_TAG_W+`DC_INDEX_W-1:0] req_ti_q;
    logic [`DC_LINE_W-1:0]            victim_line_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ms_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // snapshot of the victim, the array outputs move on after the refill
    always_ff @(posedge clk) begin
        if (state == ms_idle && miss) begin
            victim_tag_q  <= victim_tag;
            req_ti_q      <= req_tag_index;
            victim_line_q <= victim_line;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ms_idle: begin
                if (miss) begin
                    state_nxt = miss_dirty ? ms_wb_req : ms_refill_req;
                end
            end
            ms_wb_req: begin
                if (mem_resp.wr_rdy) state_nxt = ms_wb_wait;
            end
            ms_wb_wait: begin
                if (mem_resp.wr_done) state_nxt = ms_refill_req;
            end
            ms_refill_req: begin
                if (mem_resp.rd_rdy) state_nxt = ms_refill_wait;
            end
            ms_refill_wait: begin
                if (mem_resp.ret_valid) state_nxt = ms_refill_done;
            end
            ms_refill_done: state_nxt = ms_idle;
            default: state_nxt = ms_idle;
        endcase
    end

    always_comb begin
        mem_req.rd_req  = (state == ms_refill_req);
        mem_req.wr_req  = (state == ms_wb_req);
        mem_req.wr_data = victim_line_q;
        if (mem_req.wr_req) begin
            mem_req.addr = {victim_tag_q, req_ti_q[`DC_INDEX_W-1:0], {`DC_OFFSET_W{1'b0}}};
        end else begin
            mem_req.addr = {req_ti_q, {`DC_OFFSET_W{1'b0}}};
        end
    end

    // line fill lands on the ret_valid edge
    always_comb begin
        fill_wr           = '0;
        fill_wr.fill      = (state == ms_refill_wait) && mem_resp.ret_valid;
        fill_wr.index     = req_ti_q[`DC_INDEX_W-1:0];
        fill_wr.tag       = req_ti_q[`DC_TAG_W+`DC_INDEX_W-1:`DC_INDEX_W];
        fill_wr.line_data = mem_resp.ret_data;
        fill_wr.dirty     = 1'b0;
    end

    assign active      = (state != ms_idle);
    assign refill_done = (state == ms_refill_done);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.rd_req && mem_req.wr_req));

    // read request held until the memory takes it
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req.rd_req && !mem_resp.rd_rdy |=> mem_req.rd_req);

endmodule

`default_nettype wire

//--- dcache_top.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_top import dcache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    input  cpu_req_t  req,
    output logic      busy,
    output cpu_resp_t resp,
    output mem_req_t  mem_req,
    input  mem_resp_t mem_resp
);

    logic [`DC_INDEX_W-1:0]           rd_index;
    logic [`DC_TAG_W-1:0]             rd_tag;
    logic                             rd_valid;
    logic                             rd_dirty;
    logic [`DC_LINE_W-1:0]            rd_line;
    logic                             rd_en;
    logic                             miss;
    logic                             miss_dirty;
    logic [`DC_TAG_W-1:0]             victim_tag;
    logic [`DC_TAG_W+`DC_INDEX_W-1:0] req_tag_index;
    logic                             refill_done;
    logic                             active;
    array_wr_t                        st_wr;
    array_wr_t                        fill_wr;
    array_wr_t                        arr_wr;
    logic                             wr_en;

    // read on acceptance, and once more after a refill
    assign rd_en = (req_valid & ~busy) | refill_done;

    // refill owns the write port while the controller is busy
    assign arr_wr = active ? fill_wr : st_wr;
    assign wr_en  = active ? fill_wr.fill : st_wr.dirty;   // a store write always sets dirty

    dcache_lookup u_lookup (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .busy          (busy),
        .resp          (resp),
        .rd_index      (rd_index),
        .rd_tag        (rd_tag),
        .rd_valid      (rd_valid),
        .rd_dirty      (rd_dirty),
        .rd_line       (rd_line),
        .miss          (miss),
        .miss_dirty    (miss_dirty),
        .victim_tag    (victim_tag),
        .req_tag_index (req_tag_index),
        .refill_done   (refill_done),
        .st_wr         (st_wr)
    );

    dcache_arrays u_arrays (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .rd_line  (rd_line),
        .wr       (arr_wr),
        .wr_en    (wr_en)
    );

    dcache_miss_ctrl u_miss (
        .clk           (clk),
        .reset         (reset),
        .miss          (miss),
        .miss_dirty    (miss_dirty),
        .victim_tag    (victim_tag),
        .req_tag_index (req_tag_index),
        .victim_line   (rd_line),
        .mem_req       (mem_req),
        .mem_resp      (mem_resp),
        .fill_wr       (fill_wr),
        .active        (active),
        .refill_done   (refill_done)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`default_nettype none
`include "dcache_macros.svh"

module tb_mem_model import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_req_t              mem_req,
    output mem_resp_t             mem_resp,
    output int                    rd_count,
    output int                    wr_count,
    output logic [31:0]           last_rd_addr,
    output logic [31:0]           last_wr_addr,
    output logic [`DC_LINE_W-1:0] last_wr_data
);

    typedef enum logic [1:0] {
        mp_idle,    // waiting for a request, then ready after a delay
        mp_take,
        mp_ret
    } mem_phase_e;

    logic [31:0]           store [logic [31:0]];   // written words only
    mem_phase_e            phase;
    int                    delay;
    logic                  is_wr;
    logic [31:0]           addr_q;
    logic [`DC_LINE_W-1:0] line;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;   // untouched word
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            mem_resp <= '0;
            phase    <= mp_idle;
            delay    <= 0;
            rd_count <= 0;
            wr_count <= 0;
        end else begin
            mem_resp.rd_rdy    <= 1'b0;
            mem_resp.wr_rdy    <= 1'b0;
            mem_resp.ret_valid <= 1'b0;
            mem_resp.wr_done   <= 1'b0;
            case (phase)
                mp_idle: begin
                    if (mem_req.rd_req || mem_req.wr_req) begin
                        if (delay == 0) begin
                            mem_resp.rd_rdy <= mem_req.rd_req;
                            mem_resp.wr_rdy <= mem_req.wr_req;
                            phase           <= mp_take;
                        end else begin
                            delay <= delay - 1;
                        end
                    end
                end
                mp_take: begin
                    // the cache sees ready on this same edge
                    is_wr  <= mem_req.wr_req;
                    addr_q <= mem_req.addr;
                    if (mem_req.wr_req) begin
                        for (int w = 0; w < 4; w++) begin
                            store[mem_req.addr + 4*w] = mem_req.wr_data[w*32 +: 32];
                        end
                        wr_count     <= wr_count + 1;
                        last_wr_addr <= mem_req.addr;
                        last_wr_data <= mem_req.wr_data;
                    end else begin
                        rd_count     <= rd_count + 1;
                        last_rd_addr <= mem_req.addr;
                    end
                    delay <= $urandom % 6;
                    phase <= mp_ret;
                end
                default: begin
                    if (delay == 0) begin
                        for (int w = 0; w < 4; w++) begin
                            line[w*32 +: 32] = read_word(addr_q + 4*w);
                        end
                        mem_resp.wr_done   <= is_wr;
                        mem_resp.ret_valid <= !is_wr;
                        mem_resp.ret_data  <= line;
                        delay              <= $urandom % 6;
                        phase              <= mp_idle;
                    end else begin
                        delay <= delay - 1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb_dcache.sv
`default_nettype none
`include "dcache_macros.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int          TIMEOUT   = 200;
    localparam int          NUM_REQ   = 2000;
    localparam logic [31:0] ADDR_BASE = 32'h3c5a_0000;   // 64 lines above this

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    cpu_req_t              req;
    logic                  busy;
    cpu_resp_t             resp;
    mem_req_t              mem_req;
    mem_resp_t             mem_resp;
    int                    rd_count;
    int                    wr_count;
    logic [31:0]           last_rd_addr;
    logic [31:0]           last_wr_addr;
    logic [`DC_LINE_W-1:0] last_wr_data;

    // architectural word values and a shadow of the cache directory
    logic [31:0]           model_mem [logic [31:0]];
    logic                  sh_valid  [`DC_SETS];
    logic                  sh_dirty  [`DC_SETS];
    logic [`DC_TAG_W-1:0]  sh_tag    [`DC_SETS];
    int                    errors;
    int                    timeouts;
    int                    done_reqs;
    int                    resp_pulses;

    dcache_top uut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .resp      (resp),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    tb_mem_model u_mem (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .rd_count     (rd_count),
        .wr_count     (wr_count),
        .last_rd_addr (last_rd_addr),
        .last_wr_addr (last_wr_addr),
        .last_wr_data (last_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (model_mem.exists(addr)) begin
            return model_mem[addr];
        end
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;   // memory start pattern
    endfunction

    always @(negedge clk) begin
        if (!reset) begin
            assert (!(mem_req.rd_req && mem_req.wr_req)) else begin
                $display("memory read and write requests were high together at %0t", $time);
                errors++;
            end
            if (resp.valid) resp_pulses++;
        end
    end

    // ok when busy is low, so the next rising edge accepts
    task automatic wait_accept(output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        ok = !busy;
        if (!ok) begin
            $display("request not accepted within %0d cycles", TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic wait_resp(output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!resp.valid && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        ok = resp.valid;
        if (!ok) begin
            $display("no response within %0d cycles of acceptance", TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic run_request(input logic is_store, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] wstrb);
        cpu_req_t              r;
        logic [3:0]            set;
        logic [`DC_TAG_W-1:0]  tag;
        logic                  exp_hit;
        logic                  exp_wb;
        logic [31:0]           old_addr;
        logic [`DC_LINE_W-1:0] old_line;
        logic [31:0]           word;
        int                    rd0;
        int                    wr0;
        int                    w;
        logic                  ok;

        set      = addr[7:4];
        tag      = addr[31:8];
        exp_hit  = sh_valid[set] && (sh_tag[set] == tag);
        exp_wb   = !exp_hit && sh_valid[set] && sh_dirty[set];
        old_addr = {sh_tag[set], set, 4'h0};
        for (w = 0; w < 4; w++) begin
            old_line[w*32 +: 32] = model_read(old_addr + 4*w);
        end
        r.op     = is_store ? op_store : op_load;
        r.tag    = tag;
        r.index  = set;
        r.offset = addr[3:0];
        r.wdata  = wdata;
        r.wstrb  = wstrb;
        rd0      = rd_count;
        wr0      = wr_count;

        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        wait_accept(ok);
        if (!ok) return;
        @(posedge clk);
        req_valid <= 1'b0;
        wait_resp(ok);
        if (!ok) return;

        if (!is_store) begin
            word = model_read(addr);
            assert (resp.rdata == word) else begin
                $display("ERROR resp.rdata addr %h expected %h actual %h",
                         addr, word, resp.rdata);
                errors++;
            end
        end
        // a load frees the cache with its response, a store still owes its write
        assert (busy == is_store) else begin
            $display("ERROR busy at response addr %h expected %h actual %h",
                     addr, is_store, busy);
            errors++;
        end
        assert (rd_count == rd0 + (exp_hit ? 0 : 1)) else begin
            $display("ERROR mem_req.rd_req count addr %h expected %h actual %h",
                     addr, rd0 + (exp_hit ? 0 : 1), rd_count);
            errors++;
        end
        assert (exp_hit || last_rd_addr == {addr[31:4], 4'h0}) else begin
            $display("ERROR mem_req.addr refill expected %h actual %h",
                     {addr[31:4], 4'h0}, last_rd_addr);
            errors++;
        end
        assert (wr_count == wr0 + (exp_wb ? 1 : 0)) else begin
            $display("ERROR mem_req.wr_req count addr %h expected %h actual %h",
                     addr, wr0 + (exp_wb ? 1 : 0), wr_count);
            errors++;
        end
        assert (!exp_wb || (last_wr_addr == old_addr && last_wr_data == old_line)) else begin
            $display("ERROR mem_req write-back addr expected %h actual %h data expected %h actual %h",
                     old_addr, last_wr_addr, old_line, last_wr_data);
            errors++;
        end

        @(negedge clk);
        assert (!resp.valid) else begin
            $display("resp.valid stayed high for more than one cycle at %0t", $time);
            errors++;
        end

        if (!exp_hit) begin
            sh_valid[set] = 1'b1;
            sh_tag[set]   = tag;
            sh_dirty[set] = 1'b0;
        end
        if (is_store) begin
            word = model_read(addr);
            for (w = 0; w < 4; w++) begin
                if (wstrb[w]) word[w*8 +: 8] = wdata[w*8 +: 8];
            end
            model_mem[addr] = word;
            sh_dirty[set]   = 1'b1;
        end
        done_reqs++;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;

        rnd         = $urandom(37);
        errors      = 0;
        timeouts    = 0;
        done_reqs   = 0;
        resp_pulses = 0;
        reset      <= 1'b1;
        req_valid  <= 1'b0;
        req        <= '0;
        for (int s = 0; s < `DC_SETS; s++) begin
            sh_valid[s] = 1'b0;
            sh_dirty[s] = 1'b0;
            sh_tag[s]   = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        assert (!busy && !resp.valid && !mem_req.rd_req && !mem_req.wr_req) else begin
            $display("ERROR idle outputs after reset busy %h resp.valid %h rd_req %h wr_req %h",
                     busy, resp.valid, mem_req.rd_req, mem_req.wr_req);
            errors++;
        end

        // line id in bits 5:0, word in 7:6, op in 10:8, strobes in 14:11
        for (int i = 0; i < NUM_REQ && timeouts == 0; i++) begin
            rnd  = $urandom;
            addr = ADDR_BASE | {22'h0, rnd[5:0], rnd[7:6], 2'b00};
            run_request(rnd[10:8] < 3'd3, addr, $urandom, rnd[14:11]);
        end

        repeat (2) @(negedge clk);
        if (timeouts == 0) begin
            assert (resp_pulses == done_reqs) else begin
                $display("ERROR resp.valid pulses expected %h actual %h", done_reqs, resp_pulses);
                errors++;
            end
        end

        $display("errors %0d, timeouts %0d, requests completed %0d",
                 errors, timeouts, done_reqs);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
dcache_pkg.sv
dcache_arrays.sv
dcache_lookup.sv
dcache_miss_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- run.sh
#!/bin/bash
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_dcache -f flist.f -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
